/* test/soc_vectors.txt */
// op addr sel data expect, all hex, one access or action per line
// op 1 write, 2 read, 3 buttons, 4 switches, 5 idle cycles, 6 irq, 7 debug pair, 0 end
// ram byte lanes
1 20000010 f 11223344 00000000
1 20000010 3 aabbccdd 00000000
2 20000010 f 00000000 1122ccdd
1 20000010 8 ee000000 00000000
2 20000010 f 00000000 ee22ccdd
1 20000014 f 55667788 00000000
1 20000014 6 00abcd00 00000000
2 20000014 f 00000000 55abcd88
2 20000010 f 00000000 ee22ccdd
// csr banks, identifier, unmapped space
1 c0001004 f 0000a5a5 00000000
1 c0004004 f 12345678 00000000
2 c0001004 f 00000000 0000a5a5
2 c0004004 f 00000000 12345678
2 c000100c f 00000000 53334558
2 c000400c f 00000000 53334558
2 c0002004 f 00000000 00000000
2 40000000 f 00000000 00000000
1 40000000 f deadbeef 00000000
2 00000100 f 00000000 00000000
// button change on bank a
3 00000000 0 00000005 00000000
5 00000000 0 00000004 00000000
6 00000000 0 00000000 00000001
2 c0001008 f 00000000 00000005
2 c0001000 f 00000000 00000005
1 c0001008 f 00000007 00000000
2 c0001008 f 00000000 00000000
6 00000000 0 00000000 00000000
// switch change on bank b
4 00000000 0 0000000a 00000000
5 00000000 0 00000004 00000000
6 00000000 0 00000000 00000002
2 c0004008 f 00000000 0000000a
2 c0004000 f 00000000 0000000a
1 c0004008 f 0000000f 00000000
2 c0004008 f 00000000 00000000
6 00000000 0 00000000 00000000
// debug display, bus pair then gpio pair
4 00000000 0 00000000 00000000
5 00000000 0 00000002 00000000
2 c000100c f 00000000 53334558
1 20000020 f 01020304 00000000
5 00000000 0 00000002 00000000
7 00000000 0 20000020 53334558
4 00000000 0 00000001 00000000
5 00000000 0 00000002 00000000
7 00000000 0 0000a5a5 12345678
0 00000000 0 00000000 00000000

/* flist.f */
hdl/soc_pkg.sv
hdl/wb_decoder.sv
hdl/wb_bram.sv
hdl/csr_bridge.sv
hdl/sysctl_regs.sv
hdl/debug_mux.sv
hdl/soc_top.sv
test/soc_chk.sv
test/soc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the soc testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module soc_tb -f flist.f -o soc_sim

status=0
./obj_dir/soc_sim > sim.log 2>&1 || status=$?
cat sim.log

# a crash, assertion stop or missing pass line counts as a failed run
if [ "$status" -ne 0 ] || grep -q "%Error" sim.log || ! grep -qF "*** TEST PASSED ***" sim.log; then
	if ! grep -qF "*** TEST FAILED ***" sim.log; then
		echo "*** TEST FAILED ***" >> sim.log
	fi
fi

if grep -qF "*** TEST FAILED ***" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

/* test/soc_tb.sv */
// --------------------------------------------------
// soc bus backbone testbench
// --------------------------------------------------
`timescale 1ns/1ps

module soc_tb;
	import soc_pkg::*;

	// vector records of five words
	localparam int MAX_VEC  = 64;
	localparam int REC_W    = 5;
	localparam int ACK_WAIT = 10;

	logic                sys_clk;
	logic                sys_rst;
	logic [WB_ADR_W-1:0] wb_adr;
	logic [WB_DAT_W-1:0] wb_wdat;
	logic [WB_SEL_W-1:0] wb_sel;
	logic                wb_we;
	logic                wb_cyc;
	logic                wb_stb;
	logic [WB_DAT_W-1:0] wb_rdat;
	logic                wb_ack;
	logic [2:0]          btn;
	logic [3:0]          sw;
	logic [4:0]          led;
	logic [1:0]          irq;
	logic [WB_DAT_W-1:0] debug_a;
	logic [WB_DAT_W-1:0] debug_b;

	logic [31:0] vec_mem [MAX_VEC*REC_W];
	int          n_vec;
	logic        vec_ready;

	soc_top soc_top_inst (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.wb_adr_i  (wb_adr),
		.wb_dat_i  (wb_wdat),
		.wb_sel_i  (wb_sel),
		.wb_we_i   (wb_we),
		.wb_cyc_i  (wb_cyc),
		.wb_stb_i  (wb_stb),
		.wb_dat_o  (wb_rdat),
		.wb_ack_o  (wb_ack),
		.btn_i     (btn),
		.sw_i      (sw),
		.led_o     (led),
		.irq_o     (irq),
		.debug_a_o (debug_a),
		.debug_b_o (debug_b)
	);

	// 4 ns clock
	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// expected one-hot target from the address map
	function automatic logic [2:0] target_onehot(input logic [31:0] adr);
		if (adr[31:29] == REGION_BRAM)
			return 3'b001;
		else if (adr[31:30] == REGION_CSR)
			return 3'b010;
		else
			return 3'b100;
	endfunction

	// one bus cycle entered and left 1 ns after an edge
	task automatic bus_access(input logic we, input logic [31:0] adr,
			input logic [3:0] sel, input logic [31:0] wdat, output logic [31:0] rdat);
		int waited;
		waited  = 0;
		wb_adr  = adr;
		wb_sel  = sel;
		wb_we   = we;
		wb_wdat = wdat;
		wb_cyc  = 1'b1;
		wb_stb  = 1'b1;
		@(posedge sys_clk);
		#1;
		while (!wb_ack) begin
			waited++;
			if (waited >= ACK_WAIT) begin
				$display("no acknowledge for address 0x%08h within %0d cycles", adr, ACK_WAIT);
				$display("*** TEST FAILED ***");
				$fatal(1, "bus access timed out");
			end
			@(posedge sys_clk);
			#1;
		end
		rdat = wb_rdat;
		// select, cyc and we while the ack is up
		check_value("led_o", 32'(led), 32'({target_onehot(adr), 1'b1, we}));
		// master takes the ack at the next edge and then lets go
		@(posedge sys_clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(posedge sys_clk);
		#1;
		check_value("led_o", 32'(led), 32'h0);
	endtask

	// --------------------------------------------------
	// vector driven sequence
	// --------------------------------------------------
	initial begin
		logic [31:0] op;
		logic [31:0] adr;
		logic [31:0] sel;
		logic [31:0] dat;
		logic [31:0] exp;
		logic [31:0] rdat;
		int          i;
		int          v;
		sys_rst   = 1'b1;
		wb_adr    = '0;
		wb_wdat   = '0;
		wb_sel    = '0;
		wb_we     = 1'b0;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		btn       = '0;
		sw        = '0;
		n_vec     = 0;
		vec_ready = 1'b0;
		// zero fill marks the end of the list
		for (i = 0; i < MAX_VEC*REC_W; i++)
			vec_mem[i] = '0;
		$readmemh("test/soc_vectors.txt", vec_mem);
		while (n_vec < MAX_VEC && vec_mem[n_vec*REC_W] != 32'h0)
			n_vec++;
		if (n_vec == 0) begin
			$display("no vectors found in test/soc_vectors.txt");
			$display("*** TEST FAILED ***");
			$fatal(1, "empty vector list");
		end
		vec_ready = 1'b1;
		repeat (8) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		for (v = 0; v < n_vec; v++) begin
			op  = vec_mem[v*REC_W];
			adr = vec_mem[v*REC_W+1];
			sel = vec_mem[v*REC_W+2];
			dat = vec_mem[v*REC_W+3];
			exp = vec_mem[v*REC_W+4];
			case (op)
				32'h1: bus_access(1'b1, adr, sel[3:0], dat, rdat);
				32'h2: begin
					bus_access(1'b0, adr, sel[3:0], 32'h0, rdat);
					check_value("wb_dat_o", rdat, exp);
				end
				32'h3: btn = dat[2:0];
				32'h4: sw = dat[3:0];
				32'h5: begin
					repeat (dat) begin
						@(posedge sys_clk);
						#1;
					end
				end
				32'h6: check_value("irq_o", 32'(irq), exp);
				32'h7: begin
					check_value("debug_a_o", debug_a, dat);
					check_value("debug_b_o", debug_b, exp);
				end
				default: begin
					$display("unknown operation %0h in vector %0d", op, v);
					$display("*** TEST FAILED ***");
					$fatal(1, "bad vector file");
				end
			endcase
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

	// watchdog of 20 cycles per vector plus reset
	initial begin
		int limit;
		wait (vec_ready);
		limit = n_vec * 20 + 8;
		repeat (limit) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, the run did not finish", limit);
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog timeout");
	end

endmodule

/* test/soc_chk.sv */
// --------------------------------------------------
// bus handshake assertions
// --------------------------------------------------
`timescale 1ns/1ps

module soc_chk (
	input logic       sys_clk,
	input logic       sys_rst,
	input logic       wb_cyc_i,
	input logic       wb_stb_i,
	input logic       wb_ack_i,
	input logic [2:0] slave_sel_i
);

	// ack only inside an active strobe
	ack_in_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wb_ack_i |-> (wb_cyc_i && wb_stb_i))
		else $error("ack seen without cyc and stb");

	// one target named a cycle after cyc, none outside a cycle
	sel_onehot: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$onehot0(slave_sel_i) && ((slave_sel_i != 3'b000) == $past(wb_cyc_i)))
		else $error("slave select not one-hot behind cyc or set outside a cycle");

	// single-cycle ack pulse
	ack_single: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wb_ack_i |=> !wb_ack_i)
		else $error("ack high in two consecutive cycles");

endmodule

bind soc_top soc_chk soc_chk_inst (
	.sys_clk     (sys_clk),
	.sys_rst     (sys_rst),
	.wb_cyc_i    (wb_cyc_i),
	.wb_stb_i    (wb_stb_i),
	.wb_ack_i    (wb_ack_o),
	.slave_sel_i (slave_sel)
);

/* hdl/soc_top.sv */
// --------------------------------------------------
// soc bus backbone top
// --------------------------------------------------
`timescale 1ns/1ps

module soc_top (
	input  logic                         sys_clk,
	input  logic                         sys_rst,
	// master port standing in for the cpu
	input  logic [soc_pkg::WB_ADR_W-1:0] wb_adr_i,
	input  logic [soc_pkg::WB_DAT_W-1:0] wb_dat_i,
	input  logic [soc_pkg::WB_SEL_W-1:0] wb_sel_i,
	input  logic                         wb_we_i,
	input  logic                         wb_cyc_i,
	input  logic                         wb_stb_i,
	output logic [soc_pkg::WB_DAT_W-1:0] wb_dat_o,
	output logic                         wb_ack_o,
	// board
	input  logic [2:0]                   btn_i,
	input  logic [3:0]                   sw_i,
	output logic [4:0]                   led_o,
	output logic [1:0]                   irq_o,
	output logic [soc_pkg::WB_DAT_W-1:0] debug_a_o,
	output logic [soc_pkg::WB_DAT_W-1:0] debug_b_o
);
	import soc_pkg::*;

	logic                bram_stb;
	logic                bram_ack;
	logic [WB_DAT_W-1:0] bram_dat;
	logic                csrbrg_stb;
	logic                csrbrg_ack;
	logic [WB_DAT_W-1:0] csrbrg_dat;
	logic [2:0]          slave_sel;
	// csr bus
	logic [CSR_A_W-1:0]  csr_a;
	logic                csr_we;
	logic [WB_DAT_W-1:0] csr_dw;
	logic [WB_DAT_W-1:0] csr_dr_a;
	logic [WB_DAT_W-1:0] csr_dr_b;
	logic [WB_DAT_W-1:0] gpio_out_a;
	logic [WB_DAT_W-1:0] gpio_out_b;
	logic                irq_a;
	logic                irq_b;

	// --------------------------------------------------
	// bus fabric
	// --------------------------------------------------
	wb_decoder decoder_inst (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.wb_adr_i    (wb_adr_i),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_ack_o    (wb_ack_o),
		.wb_dat_o    (wb_dat_o),
		.bram_stb_o  (bram_stb),
		.bram_ack_i  (bram_ack),
		.bram_dat_i  (bram_dat),
		.csr_stb_o   (csrbrg_stb),
		.csr_ack_i   (csrbrg_ack),
		.csr_dat_i   (csrbrg_dat),
		.slave_sel_o (slave_sel)
	);

	// word address from byte address
	wb_bram bram_inst (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.stb_i   (bram_stb),
		.we_i    (wb_we_i),
		.adr_i   (wb_adr_i[BRAM_ADR_W+1:2]),
		.sel_i   (wb_sel_i),
		.dat_i   (wb_dat_i),
		.ack_o   (bram_ack),
		.dat_o   (bram_dat)
	);

	// banks drive zero when not addressed, so OR them
	csr_bridge csrbrg_inst (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.stb_i    (csrbrg_stb),
		.we_i     (wb_we_i),
		.adr_i    (wb_adr_i),
		.dat_i    (wb_dat_i),
		.ack_o    (csrbrg_ack),
		.dat_o    (csrbrg_dat),
		.csr_a_o  (csr_a),
		.csr_we_o (csr_we),
		.csr_dw_o (csr_dw),
		.csr_dr_i (csr_dr_a | csr_dr_b)
	);

	// --------------------------------------------------
	// system controllers
	// --------------------------------------------------
	// bank a on the buttons
	sysctl_regs #(
		.CSR_BANK (CSR_BANK_A),
		.N_IN     (3)
	) sysctl_a_inst (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.csr_a_i  (csr_a),
		.csr_we_i (csr_we),
		.csr_dw_i (csr_dw),
		.csr_dr_o (csr_dr_a),
		.gpio_i   (btn_i),
		.gpio_o   (gpio_out_a),
		.irq_o    (irq_a)
	);

	// bank b on the switches
	sysctl_regs #(
		.CSR_BANK (CSR_BANK_B),
		.N_IN     (4)
	) sysctl_b_inst (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.csr_a_i  (csr_a),
		.csr_we_i (csr_we),
		.csr_dw_i (csr_dw),
		.csr_dr_o (csr_dr_b),
		.gpio_i   (sw_i),
		.gpio_o   (gpio_out_b),
		.irq_o    (irq_b)
	);

	debug_mux debug_inst (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.sw_i      (sw_i),
		.wb_ack_i  (wb_ack_o),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_rdat_i (wb_dat_o),
		.gpio_a_i  (gpio_out_a),
		.gpio_b_i  (gpio_out_b),
		.debug_a_o (debug_a_o),
		.debug_b_o (debug_b_o)
	);

	// activity leds and interrupt lines
	assign led_o = {slave_sel, wb_cyc_i, wb_we_i};
	assign irq_o = {irq_b, irq_a};

endmodule

/* hdl/debug_mux.sv */
// --------------------------------------------------
// debug display select
// --------------------------------------------------
`timescale 1ns/1ps

module debug_mux (
	input  logic                         sys_clk,
	input  logic                         sys_rst,
	input  logic [3:0]                   sw_i,
	input  logic                         wb_ack_i,
	input  logic                         wb_we_i,
	input  logic [soc_pkg::WB_ADR_W-1:0] wb_adr_i,
	input  logic [soc_pkg::WB_DAT_W-1:0] wb_rdat_i,
	input  logic [soc_pkg::WB_DAT_W-1:0] gpio_a_i,
	input  logic [soc_pkg::WB_DAT_W-1:0] gpio_b_i,
	output logic [soc_pkg::WB_DAT_W-1:0] debug_a_o,
	output logic [soc_pkg::WB_DAT_W-1:0] debug_b_o
);
	import soc_pkg::*;

	logic [WB_ADR_W-1:0] last_adr;
	logic [WB_DAT_W-1:0] last_rdat;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			last_adr  <= '0;
			last_rdat <= '0;
			debug_a_o <= '0;
			debug_b_o <= '0;
		end else begin
			// track last acknowledged access
			if (wb_ack_i)
				last_adr <= wb_adr_i;
			if (wb_ack_i & ~wb_we_i)
				last_rdat <= wb_rdat_i;
			// bus pair for DBG_BUS and unknown codes
			case (sw_i)
				DBG_GPIO: begin
					debug_a_o <= gpio_a_i;
					debug_b_o <= gpio_b_i;
				end
				default: begin
					debug_a_o <= last_adr;
					debug_b_o <= last_rdat;
				end
			endcase
		end
	end

endmodule

/* hdl/sysctl_regs.sv */
// --------------------------------------------------
// system controller register bank
// --------------------------------------------------
`timescale 1ns/1ps

module sysctl_regs #(
	parameter logic [soc_pkg::CSR_BANK_W-1:0] CSR_BANK = soc_pkg::CSR_BANK_A,
	parameter int                             N_IN     = 3
) (
	input  logic                         sys_clk,
	input  logic                         sys_rst,
	input  logic [soc_pkg::CSR_A_W-1:0]  csr_a_i,
	input  logic                         csr_we_i,
	input  logic [soc_pkg::WB_DAT_W-1:0] csr_dw_i,
	output logic [soc_pkg::WB_DAT_W-1:0] csr_dr_o,
	input  logic [N_IN-1:0]              gpio_i,
	output logic [soc_pkg::WB_DAT_W-1:0] gpio_o,
	output logic                         irq_o
);
	import soc_pkg::*;

	logic [N_IN-1:0]     in_meta;
	logic [N_IN-1:0]     in_sync;
	logic [N_IN-1:0]     in_last;
	logic [N_IN-1:0]     pending;
	logic                bank_hit;
	csr_reg_e            reg_idx;
	logic [WB_DAT_W-1:0] in_word;
	logic [WB_DAT_W-1:0] pend_word;

	assign bank_hit = (csr_a_i[CSR_A_W-1 -: CSR_BANK_W] == CSR_BANK);
	assign reg_idx  = csr_reg_e'(csr_a_i[1:0]);

	// --------------------------------------------------
	// inputs and change interrupt
	// --------------------------------------------------
	// two-flop sync, third flop for edge detect
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			in_meta <= '0;
			in_sync <= '0;
			in_last <= '0;
			pending <= '0;
		end else begin
			in_meta <= gpio_i;
			in_sync <= in_meta;
			in_last <= in_sync;
			// new change wins over a clear
			if (csr_we_i & bank_hit & (reg_idx == CSR_IRQ))
				pending <= (pending & ~csr_dw_i[N_IN-1:0]) | (in_sync ^ in_last);
			else
				pending <= pending | (in_sync ^ in_last);
		end
	end

	assign irq_o = |pending;

	// output register
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			gpio_o <= '0;
		else if (csr_we_i & bank_hit & (reg_idx == CSR_GPIO_OUT))
			gpio_o <= csr_dw_i;
	end

	// read side, zero unless our bank
	always_comb begin
		in_word               = '0;
		in_word[N_IN-1:0]     = in_sync;
		pend_word             = '0;
		pend_word[N_IN-1:0]   = pending;
		csr_dr_o              = '0;
		if (bank_hit) begin
			case (reg_idx)
				CSR_GPIO_IN:  csr_dr_o = in_word;
				CSR_GPIO_OUT: csr_dr_o = gpio_o;
				CSR_IRQ:      csr_dr_o = pend_word;
				CSR_SYSID:    csr_dr_o = SYSTEM_ID;
				default:      csr_dr_o = '0;
			endcase
		end
	end

endmodule

/* hdl/csr_bridge.sv */
// --------------------------------------------------
// wishbone to csr bridge
// --------------------------------------------------
`timescale 1ns/1ps

module csr_bridge (
	input  logic                         sys_clk,
	input  logic                         sys_rst,
	input  logic                         stb_i,
	input  logic                         we_i,
	input  logic [soc_pkg::WB_ADR_W-1:0] adr_i,
	input  logic [soc_pkg::WB_DAT_W-1:0] dat_i,
	output logic                         ack_o,
	output logic [soc_pkg::WB_DAT_W-1:0] dat_o,
	// csr bus
	output logic [soc_pkg::CSR_A_W-1:0]  csr_a_o,
	output logic                         csr_we_o,
	output logic [soc_pkg::WB_DAT_W-1:0] csr_dw_o,
	input  logic [soc_pkg::WB_DAT_W-1:0] csr_dr_i
);
	import soc_pkg::*;

	typedef enum logic {ST_IDLE, ST_CAPTURE} state_e;

	state_e state;
	logic   start;

	// no restart while the master still sees our ack
	assign start = (state == ST_IDLE) & stb_i & ~ack_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state    <= ST_IDLE;
			ack_o    <= 1'b0;
			csr_we_o <= 1'b0;
		end else begin
			// write strobe lasts one cycle
			csr_we_o <= start & we_i;
			ack_o    <= (state == ST_CAPTURE);
			state    <= start ? ST_CAPTURE : ST_IDLE;
		end
	end

	// first cycle presents address, second grabs read data
	always_ff @(posedge sys_clk) begin
		if (start) begin
			csr_a_o  <= adr_i[CSR_A_W+1:2];
			csr_dw_o <= dat_i;
		end
		if (state == ST_CAPTURE)
			dat_o <= csr_dr_i;
	end

endmodule

/* hdl/wb_bram.sv */
// --------------------------------------------------
// word ram slave
// --------------------------------------------------
`timescale 1ns/1ps

module wb_bram (
	input  logic                           sys_clk,
	input  logic                           sys_rst,
	input  logic                           stb_i,
	input  logic                           we_i,
	input  logic [soc_pkg::BRAM_ADR_W-1:0] adr_i,
	input  logic [soc_pkg::WB_SEL_W-1:0]   sel_i,
	input  logic [soc_pkg::WB_DAT_W-1:0]   dat_i,
	output logic                           ack_o,
	output logic [soc_pkg::WB_DAT_W-1:0]   dat_o
);
	import soc_pkg::*;

	logic [WB_DAT_W-1:0] mem [2**BRAM_ADR_W];

	// single ack per access
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			ack_o <= 1'b0;
		else
			ack_o <= stb_i & ~ack_o;
	end

	// read before write, only enabled lanes written
	always_ff @(posedge sys_clk) begin
		if (stb_i) begin
			dat_o <= mem[adr_i];
			for (int i = 0; i < WB_SEL_W; i++) begin
				if (we_i & sel_i[i] & ~ack_o)
					mem[adr_i][8*i +: 8] <= dat_i[8*i +: 8];
			end
		end
	end

endmodule

/* hdl/wb_decoder.sv */
// --------------------------------------------------
// wishbone address decoder
// --------------------------------------------------
`timescale 1ns/1ps

module wb_decoder (
	input  logic                         sys_clk,
	input  logic                         sys_rst,
	// master side
	input  logic [soc_pkg::WB_ADR_W-1:0] wb_adr_i,
	input  logic                         wb_cyc_i,
	input  logic                         wb_stb_i,
	output logic                         wb_ack_o,
	output logic [soc_pkg::WB_DAT_W-1:0] wb_dat_o,
	// block ram
	output logic                         bram_stb_o,
	input  logic                         bram_ack_i,
	input  logic [soc_pkg::WB_DAT_W-1:0] bram_dat_i,
	// csr bridge
	output logic                         csr_stb_o,
	input  logic                         csr_ack_i,
	input  logic [soc_pkg::WB_DAT_W-1:0] csr_dat_i,
	// activity indicator
	output logic [2:0]                   slave_sel_o
);
	import soc_pkg::*;

	slave_e slv;
	logic   req;
	logic   none_ack;

	// region decode, ram checked first
	always_comb begin
		if (wb_adr_i[WB_ADR_W-1 -: 3] == REGION_BRAM)
			slv = SLV_BRAM;
		else if (wb_adr_i[WB_ADR_W-1 -: 2] == REGION_CSR)
			slv = SLV_CSR;
		else
			slv = SLV_NONE;
	end

	assign req        = wb_cyc_i & wb_stb_i;
	assign bram_stb_o = req & (slv == SLV_BRAM);
	assign csr_stb_o  = req & (slv == SLV_CSR);

	// --------------------------------------------------
	// unmapped responder
	// --------------------------------------------------
	// one-cycle ack, never twice in a row
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			none_ack <= 1'b0;
		else
			none_ack <= req & (slv == SLV_NONE) & ~none_ack;
	end

	// return path
	always_comb begin
		case (slv)
			SLV_BRAM: begin
				wb_ack_o = bram_ack_i;
				wb_dat_o = bram_dat_i;
			end
			SLV_CSR: begin
				wb_ack_o = csr_ack_i;
				wb_dat_o = csr_dat_i;
			end
			default: begin
				wb_ack_o = none_ack;
				wb_dat_o = '0;
			end
		endcase
	end

	// registered one-hot select, cleared outside a cycle
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			slave_sel_o <= '0;
		else if (wb_cyc_i)
			slave_sel_o <= 3'b001 << slv;
		else
			slave_sel_o <= '0;
	end

endmodule

/* hdl/soc_pkg.sv */
// --------------------------------------------------
// soc bus backbone definitions
// --------------------------------------------------

package soc_pkg;

	// wishbone widths
	localparam int WB_ADR_W = 32;
	localparam int WB_DAT_W = 32;
	localparam int WB_SEL_W = 4;

	// region codes on the top address bits
	// 0x2000_0000 range
	localparam logic [2:0] REGION_BRAM = 3'b001;
	// 0xC000_0000 and up
	localparam logic [1:0] REGION_CSR = 2'b11;

	// block ram word address
	localparam int BRAM_ADR_W = 10;

	// csr bus taken from byte address bits 15..2
	localparam int CSR_A_W = 14;
	localparam int CSR_BANK_W = 4;

	// identifier seen in every bank
	localparam logic [31:0] SYSTEM_ID = 32'h53334558;

	// bank numbers on the csr bus
	localparam logic [CSR_BANK_W-1:0] CSR_BANK_A = 4'd1;
	localparam logic [CSR_BANK_W-1:0] CSR_BANK_B = 4'd4;

	// bus targets, value is the bit in the one-hot select
	typedef enum logic [1:0] {
		SLV_BRAM = 2'd0,
		SLV_CSR  = 2'd1,
		SLV_NONE = 2'd2
	} slave_e;

	// register index in the low two csr address bits
	typedef enum logic [1:0] {
		CSR_GPIO_IN  = 2'd0,
		CSR_GPIO_OUT = 2'd1,
		CSR_IRQ      = 2'd2,
		CSR_SYSID    = 2'd3
	} csr_reg_e;

	// debug display switch codes
	typedef enum logic [3:0] {
		DBG_BUS  = 4'b0000,
		DBG_GPIO = 4'b0001
	} dbg_sel_e;

endpackage
